//--- all.f
+incdir+design
design/fetch_pkg.sv
design/branch_reg_file.sv
design/imm_gen.sv
design/branch_compare.sv
design/pc_sequencer.sv
design/fetch_branch_top.sv
bench/tb_fetch_branch.sv

//--- run.sh
#!/bin/sh
# Build and run the fetch/branch testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f all.f \
    --top-module tb_fetch_branch \
    -Mdir obj_dir -o sim_fetch_branch

./obj_dir/sim_fetch_branch | tee sim.log

if grep -q "NO ERRORS" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- bench/tb_fetch_branch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_branch
    import fetch_pkg::*;
();

    localparam int         MAX_ROWS   = 128;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;   // RV B-type opcode
    localparam logic [6:0] OPC_OP     = 7'b0110011;   // R-type ALU op, never branches
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    logic      clk = 1'b0;
    logic      reset;
    logic      advance;
    instr_t    instr;
    rf_write_t rf_wr;
    pc_t       pc;

    // Stimulus table, one entry per cycle
    string       row_name  [MAX_ROWS];
    bit          row_we    [MAX_ROWS];
    logic [4:0]  row_waddr [MAX_ROWS];
    logic [63:0] row_wdata [MAX_ROWS];
    logic [6:0]  row_opc   [MAX_ROWS];
    logic [2:0]  row_f3    [MAX_ROWS];
    logic [4:0]  row_rs1   [MAX_ROWS];
    logic [4:0]  row_rs2   [MAX_ROWS];
    int          row_imm   [MAX_ROWS];   // Byte offset, even, 13-bit signed range
    bit          row_adv   [MAX_ROWS];
    int          row_cnt     = 0;
    bit          table_ready = 1'b0;

    logic [63:0] shadow [32];            // Reference copy of the register file
    int          seed = 32'h4cf75568;

    fetch_branch_top fetch_branch_top_inst (
        .clk     (clk),
        .reset   (reset),
        .advance (advance),
        .instr   (instr),
        .rf_wr   (rf_wr),
        .pc      (pc)
    );

    always #50 clk = ~clk;               // 100 ns period

    // Pack fields per the RV B-type layout
    function automatic instr_t encode_b_type(input logic [6:0] opc, input logic [2:0] f3,
                                             input logic [4:0] rs1, input logic [4:0] rs2,
                                             input int imm);
        logic [12:0] b;
        b = 13'(imm);                    // Bit 0 is dropped by the format
        return {b[12], b[10:5], rs2, rs1, f3, b[4:1], b[11], opc};
    endfunction

    task automatic check_value(input string name, input pc_t expected, input pc_t actual);
        if (expected !== actual) begin
            $display("ERROR %s expected %0d actual %0d", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "pc mismatch");
        end
    endtask

    task automatic append_row(input string name, input bit we, input logic [4:0] waddr,
                              input logic [63:0] wdata, input logic [6:0] opc,
                              input logic [2:0] f3, input logic [4:0] rs1,
                              input logic [4:0] rs2, input int imm, input bit adv);
        if (row_cnt >= MAX_ROWS) begin
            $display("Stimulus table is full, row %s does not fit", name);
            $display("ERRORS FOUND");
            $fatal(1, "table overflow");
        end
        row_name[row_cnt]  = name;
        row_we[row_cnt]    = we;
        row_waddr[row_cnt] = waddr;
        row_wdata[row_cnt] = wdata;
        row_opc[row_cnt]   = opc;
        row_f3[row_cnt]    = f3;
        row_rs1[row_cnt]   = rs1;
        row_rs2[row_cnt]   = rs2;
        row_imm[row_cnt]   = imm;
        row_adv[row_cnt]   = adv;
        row_cnt++;
    endtask

    // ALU op on x1 and x2, which hold equal values, so equality alone must not branch
    task automatic insert_nop(input string name, input bit adv);
        append_row(name, 1'b0, 5'd0, 64'd0, OPC_OP, 3'b000, 5'd1, 5'd2, 0, adv);
    endtask

    task automatic preload_reg(input string name, input logic [4:0] addr,
                               input logic [63:0] data);
        append_row(name, 1'b1, addr, data, OPC_OP, 3'b000, 5'd0, 5'd0, 0, 1'b1);
    endtask

    task automatic schedule_branch(input string name, input logic [2:0] f3,
                                   input logic [4:0] rs1, input logic [4:0] rs2,
                                   input int imm, input bit adv);
        append_row(name, 1'b0, 5'd0, 64'd0, OPC_BRANCH, f3, rs1, rs2, imm, adv);
    endtask

    task automatic build_table();
        logic [63:0] r_a;
        logic [63:0] r_b;
        r_a = {$random(seed), $random(seed)};
        r_b = {$random(seed), $random(seed)};
        for (int k = 0; k < 64; k++) begin
            insert_nop($sformatf("seq_%0d", k), 1'b1);   // Last one wraps 252 to 0
        end
        preload_reg("wr_x1", 5'd1, r_a);
        preload_reg("wr_x2", 5'd2, r_a);                 // Equal random pair
        preload_reg("wr_x3", 5'd3, r_a ^ (64'd1 << 40)); // Differs far above bit 7
        preload_reg("wr_x10", 5'd10, r_a ^ 64'h100);     // Differs just above bit 7
        preload_reg("wr_x4", 5'd4, 64'd0);
        preload_reg("wr_x5", 5'd5, 64'd5);
        preload_reg("wr_x6", 5'd6, 64'd6);
        preload_reg("wr_x7", 5'd7, r_b);
        preload_reg("wr_x8", 5'd8, r_b);
        preload_reg("wr_x0", 5'd0, 64'hdead_beef_0bad_f00d);  // Must be dropped
        schedule_branch("beq_eq_pos", F3_BEQ, 5'd1, 5'd2, 16, 1'b1);
        schedule_branch("beq_eq_neg", F3_BEQ, 5'd7, 5'd8, -40, 1'b1);
        schedule_branch("beq_ne_bit40", F3_BEQ, 5'd1, 5'd3, 32, 1'b1);
        schedule_branch("beq_ne_bit8", F3_BEQ, 5'd1, 5'd10, 32, 1'b1);
        schedule_branch("beq_ne_low", F3_BEQ, 5'd5, 5'd6, 8, 1'b1);
        schedule_branch("beq_x0_x4", F3_BEQ, 5'd0, 5'd4, 12, 1'b1);
        schedule_branch("beq_x4_x0", F3_BEQ, 5'd4, 5'd0, -6, 1'b1);   // x0 on port 2
        schedule_branch("bne_eq", F3_BNE, 5'd1, 5'd2, 24, 1'b1);
        append_row("alu_eq", 1'b0, 5'd0, 64'd0, OPC_OP, 3'b000, 5'd7, 5'd8, 24, 1'b1);
        schedule_branch("beq_big_pos", F3_BEQ, 5'd1, 5'd2, 2000, 1'b1);   // Truncated to 8 bits
        schedule_branch("beq_big_neg", F3_BEQ, 5'd7, 5'd8, -4096, 1'b1);
        // Write and read of the same register in one cycle sees the old value
        append_row("wr_x9_same_cycle", 1'b1, 5'd9, r_a, OPC_BRANCH, F3_BEQ,
                   5'd1, 5'd9, 20, 1'b1);
        schedule_branch("beq_after_wr", F3_BEQ, 5'd1, 5'd9, 20, 1'b1);
        schedule_branch("hold_beq", F3_BEQ, 5'd1, 5'd2, 64, 1'b0);
        insert_nop("hold_nop", 1'b0);
        append_row("hold_wr", 1'b1, 5'd11, 64'd77, OPC_OP, 3'b000, 5'd0, 5'd0, 0, 1'b0);
        schedule_branch("hold_beq_ne", F3_BEQ, 5'd5, 5'd6, 8, 1'b0);
        insert_nop("resume_nop", 1'b1);
        schedule_branch("resume_beq", F3_BEQ, 5'd7, 5'd8, 100, 1'b1);
        insert_nop("tail_0", 1'b1);
        insert_nop("tail_1", 1'b1);
    endtask

    // Watchdog sized from the table length
    initial begin
        time limit;
        wait (table_ready);
        limit = (row_cnt + 8 + 16) * 100;
        #(limit);
        $display("Watchdog: the run did not finish in its time limit");
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

    initial begin
        pc_t         exp_pc;
        logic [63:0] v1;
        logic [63:0] v2;
        bit          taken;
        reset   = 1'b1;
        advance = 1'b0;
        instr   = '0;
        rf_wr   = '0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = 64'd0;            // Reset clears the file
        end
        build_table();
        table_ready = 1'b1;

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset  = 1'b0;
        exp_pc = 8'd0;
        check_value("after_reset", exp_pc, pc);

        for (int i = 0; i < row_cnt; i++) begin
            // Inputs change on the falling edge only
            advance     = row_adv[i];
            rf_wr.we    = row_we[i];
            rf_wr.addr  = row_waddr[i];
            rf_wr.data  = row_wdata[i];
            instr       = encode_b_type(row_opc[i], row_f3[i], row_rs1[i],
                                        row_rs2[i], row_imm[i]);

            // Operands read before this cycle's write lands
            v1 = (row_rs1[i] == 5'd0) ? 64'd0 : shadow[row_rs1[i]];
            v2 = (row_rs2[i] == 5'd0) ? 64'd0 : shadow[row_rs2[i]];
            taken = (row_opc[i] == OPC_BRANCH) && (row_f3[i] == F3_BEQ) && (v1 == v2);
            if (row_adv[i]) begin
                if (taken) begin
                    exp_pc = exp_pc + 8'(row_imm[i]);   // Modulo 256
                end else begin
                    exp_pc = exp_pc + 8'd4;
                end
            end
            if (row_we[i] && row_waddr[i] != 5'd0) begin
                shadow[row_waddr[i]] = row_wdata[i];
            end

            @(negedge clk);                               // pc settled after the edge
            check_value(row_name[i], exp_pc, pc);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/fetch_branch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_branch_top
    import fetch_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  logic      advance,   // Gates the PC update
    input  instr_t    instr,     // Instruction from external memory model
    input  rf_write_t rf_wr,     // Register preload port
    output pc_t       pc         // Fetch address
);

    reg_addr_t   rs1_addr;       // Decoded source indices
    reg_addr_t   rs2_addr;
    logic        is_beq;
    xlen_t       offset;
    rf_read_t    rd_vals;        // Register operands
    branch_req_t br;             // Decision to sequencer

    imm_gen imm_gen_inst (
        .instr    (instr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .is_beq   (is_beq),
        .offset   (offset)
    );

    branch_reg_file branch_reg_file_inst (
        .clk      (clk),
        .reset    (reset),
        .rf_wr    (rf_wr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_vals  (rd_vals)
    );

    branch_compare branch_compare_inst (
        .rd_vals (rd_vals),
        .is_beq  (is_beq),
        .offset  (offset),
        .br      (br)
    );

    pc_sequencer pc_sequencer_inst (
        .clk     (clk),
        .reset   (reset),
        .advance (advance),
        .br      (br),
        .pc      (pc)
    );

endmodule

`default_nettype wire

//--- design/pc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module pc_sequencer
    import fetch_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  logic        advance,    // Level, PC moves only while high
    input  branch_req_t br,         // Taken bit and halfword offset
    output pc_t         pc          // Current instruction address
);

    pc_t   pc_q;                    // PC register
    pc_t   pc_plus_4;               // Sequential candidate
    pc_t   branch_target;           // Branch candidate, low bits only
    pc_t   pc_next;                 // Selected candidate

    xlen_t pc_ext;                  // PC widened to register size
    xlen_t imm_shifted;             // Offset in bytes
    xlen_t target_full;             // Full-width branch sum

    // Wraps modulo 256 by width alone
    assign pc_plus_4 = pc_q + pc_t'(`PC_STEP);

    // Zero extend the address
    assign pc_ext = {{(`XLEN-`PC_W){1'b0}}, pc_q};

    // Halfword count doubled into a byte offset
    assign imm_shifted = {br.offset[`XLEN-2:0], 1'b0};

    // Add at 64 bits, then keep the address bits
    assign target_full   = pc_ext + imm_shifted;
    assign branch_target = target_full[`PC_W-1:0];

    // Taken selects the target, otherwise fall through
    always_comb begin
        if (br.taken) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc_plus_4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= `RESET_PC;
        end else if (advance) begin
            pc_q <= pc_next;        // Load only when advancing
        end
    end

    // Hold otherwise, no other stall source

    assign pc = pc_q;

endmodule

`default_nettype wire

//--- design/branch_compare.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module branch_compare
    import fetch_pkg::*;
(
    input  rf_read_t    rd_vals,   // Operands from the register file
    input  logic        is_beq,    // Decode result from imm_gen
    input  xlen_t       offset,    // Halfword offset from imm_gen
    output branch_req_t br         // Decision toward the sequencer
);

    xlen_t diff;                   // rs1 - rs2 over all 64 bits
    logic  zero_flag;              // Operands equal

    // Full-width subtract, so bits above 7 count too
    assign diff = rd_vals.rs1_val - rd_vals.rs2_val;

    assign zero_flag = (diff == '0);

    // Equal operands alone do not branch
    assign br.taken  = is_beq & zero_flag;

    // Offset travels unchanged beside the decision
    assign br.offset = offset;

endmodule

`default_nettype wire

//--- design/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module imm_gen
    import fetch_pkg::*;
(
    input  instr_t    instr,      // Instruction word of this cycle
    output reg_addr_t rs1_addr,   // Source register 1 index
    output reg_addr_t rs2_addr,   // Source register 2 index
    output logic      is_beq,     // Instruction is a BEQ
    output xlen_t     offset      // B-type immediate as halfword count
);

    logic [6:0]  opcode;          // Major opcode field
    logic [2:0]  funct3;          // Minor opcode field
    logic [11:0] imm_hw;          // imm[12:1], bit 0 is implicit zero

    // Fixed RISC-V field positions
    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // Both fields must match
    assign is_beq = (opcode == `OPC_BRANCH) && (funct3 == `F3_BEQ);

    // Scattered B-type bits gathered back in order
    assign imm_hw = {
        instr[31],       // imm[12], sign
        instr[7],        // imm[11]
        instr[30:25],    // imm[10:5]
        instr[11:8]      // imm[4:1]
    };

    // Sign extend to full register width
    assign offset = {{(`XLEN-12){imm_hw[11]}}, imm_hw};

    // Sequencer shifts this left by one to get a byte offset
    // Other instruction types still drive offset, it is just unused

endmodule

`default_nettype wire

//--- design/branch_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module branch_reg_file
    import fetch_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  rf_write_t rf_wr,      // Write port driven from outside
    input  reg_addr_t rs1_addr,   // First read index
    input  reg_addr_t rs2_addr,   // Second read index
    output rf_read_t  rd_vals     // Both read values
);

    xlen_t regs [`REG_CNT];       // Architectural registers

    logic wr_en;                  // Qualified write, x0 excluded

    // x0 is hardwired, so a write there is dropped
    assign wr_en = rf_wr.we && (rf_wr.addr != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;    // Clear every entry
            end
        end else if (wr_en) begin
            regs[rf_wr.addr] <= rf_wr.data;
        end
    end

    // Asynchronous reads, no same-cycle bypass
    always_comb begin
        if (rs1_addr == '0) begin
            rd_vals.rs1_val = '0;                 // x0 always reads zero
        end else begin
            rd_vals.rs1_val = regs[rs1_addr];
        end
    end

    always_comb begin
        if (rs2_addr == '0) begin
            rd_vals.rs2_val = '0;                 // Same rule on port 2
        end else begin
            rd_vals.rs2_val = regs[rs2_addr];
        end
    end

endmodule

`default_nettype wire

//--- design/fetch_pkg.sv
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

    // Plain vector types
    typedef logic [`PC_W-1:0]              pc_t;        // Byte address into fetch space
    typedef logic [`XLEN-1:0]              xlen_t;      // Register value
    typedef logic [$clog2(`REG_CNT)-1:0]   reg_addr_t;  // Register index
    typedef logic [31:0]                   instr_t;     // Raw instruction word

    // External write into the register file
    typedef struct packed {
        logic      we;     // Write strobe, one cycle
        reg_addr_t addr;   // Destination register
        xlen_t     data;   // Value to store
    } rf_write_t;

    // Branch decision toward the sequencer
    typedef struct packed {
        logic  taken;      // BEQ and operands equal
        xlen_t offset;     // Halfword count, sign extended
    } branch_req_t;

    // Both read ports of the register file
    typedef struct packed {
        xlen_t rs1_val;
        xlen_t rs2_val;
    } rf_read_t;

endpackage

`default_nettype wire

//--- design/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

`define PC_W       8            // Instruction address width
`define XLEN       64           // Register width
`define REG_CNT    32           // Architectural register count
`define PC_STEP    4            // Sequential fetch increment
`define RESET_PC   8'd0         // PC after reset

`define OPC_BRANCH 7'b1100011   // B-type major opcode
`define F3_BEQ     3'b000       // Funct3 for BEQ

`endif
